/* ccl_defs.svh */
`ifndef CCL_DEFS_SVH
`define CCL_DEFS_SVH

// frame geometry
`define CCL_WIDTH 16
`define CCL_HEIGHT 12
`define CCL_PIX_COUNT (`CCL_WIDTH * `CCL_HEIGHT)
`define CCL_ADDR_W $clog2(`CCL_PIX_COUNT)

// label 0 is background
`define CCL_LABEL_W 7
// holds a full-frame blob of 192 pixels
`define CCL_AREA_W 8

// pruning threshold out of reset
`define CCL_MIN_AREA_RESET 3

`endif

/* ccl_frame_pkg.sv */
`default_nettype none
`include "ccl_defs.svh"

package ccl_frame_pkg;
    typedef logic [$clog2(`CCL_WIDTH)-1:0] coord_x_t;
    typedef logic [$clog2(`CCL_HEIGHT)-1:0] coord_y_t;
    // raster address, row * width + column
    typedef logic [`CCL_ADDR_W-1:0] pix_addr_t;
    typedef enum logic [2:0] {PH_IDLE, PH_STORE, PH_SCAN, PH_RESOLVE, PH_SELECT} ccl_phase_t;
endpackage

`default_nettype wire

/* ccl_label_pkg.sv */
`default_nettype none
`include "ccl_defs.svh"

package ccl_label_pkg;
    // provisional or root label
    typedef logic [`CCL_LABEL_W-1:0] label_t;
    // pixel count of one label
    typedef logic [`CCL_AREA_W-1:0] area_t;
    // surviving blobs in a frame
    typedef logic [`CCL_LABEL_W-1:0] blob_count_t;
endpackage

`default_nettype wire

/* pixel_ram.sv */
`default_nettype none

module pixel_ram #(
    parameter int data_width = 1,
    parameter int depth = 192
) (
    input  wire logic                     clk_in,
    input  wire logic                     we,
    input  wire logic [$clog2(depth)-1:0] waddr,
    input  wire logic [data_width-1:0]    wdata,
    input  wire logic [$clog2(depth)-1:0] raddr_a,
    output logic      [data_width-1:0]    rdata_a,
    input  wire logic [$clog2(depth)-1:0] raddr_b,
    output logic      [data_width-1:0]    rdata_b
);
    logic [data_width-1:0] mem [depth];

    // read-first, one cycle of read latency on both ports
    always_ff @(posedge clk_in) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end
endmodule

`default_nettype wire

/* ccl_config.sv */
`default_nettype none
`include "ccl_defs.svh"

module ccl_config import ccl_label_pkg::*; (
    input  wire logic  clk_in,
    input  wire logic  rst_in,
    input  wire logic  cfg_valid,
    input  wire area_t cfg_min_area,
    input  wire logic  busy,
    output area_t      min_area
);
    // threshold only moves between frames
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            min_area <= area_t'(`CCL_MIN_AREA_RESET);
        end else if (cfg_valid && !busy) begin
            min_area <= cfg_min_area;
        end
    end
endmodule

`default_nettype wire

/* ccl_ctrl.sv */
`default_nettype none
`include "ccl_defs.svh"

module ccl_ctrl import ccl_frame_pkg::*; (
    input  wire logic clk_in,
    input  wire logic rst_in,
    input  wire logic frame_start,
    input  wire logic pixel_valid,
    output logic      mask_we,
    output pix_addr_t mask_waddr,
    output logic      scan_start,
    input  wire logic scan_done,
    output logic      resolve_start,
    input  wire logic resolve_done,
    output logic      select_start,
    input  wire logic select_done,
    output logic      busy,
    output logic      result_valid
);
    ccl_phase_t phase;
    pix_addr_t  pix_cnt;

    // every pixel_valid in store is taken, no stall
    assign mask_we = (phase == PH_STORE) && pixel_valid;
    assign mask_waddr = pix_cnt;
    assign busy = (phase != PH_IDLE);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            phase <= PH_IDLE;
            pix_cnt <= '0;
            scan_start <= 1'b0;
            resolve_start <= 1'b0;
            select_start <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            // start strobes are single-cycle
            scan_start <= 1'b0;
            resolve_start <= 1'b0;
            select_start <= 1'b0;
            result_valid <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (frame_start) begin
                        phase <= PH_STORE;
                        pix_cnt <= '0;
                    end
                end
                PH_STORE: begin
                    if (pixel_valid) begin
                        // last raster address closes the frame
                        if (pix_cnt == pix_addr_t'(`CCL_PIX_COUNT - 1)) begin
                            phase <= PH_SCAN;
                            scan_start <= 1'b1;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                        end
                    end
                end
                PH_SCAN: begin
                    if (scan_done) begin
                        phase <= PH_RESOLVE;
                        resolve_start <= 1'b1;
                    end
                end
                PH_RESOLVE: begin
                    if (resolve_done) begin
                        phase <= PH_SELECT;
                        select_start <= 1'b1;
                    end
                end
                PH_SELECT: begin
                    // busy drops with the result strobe
                    if (select_done) begin
                        phase <= PH_IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end
endmodule

`default_nettype wire

/* label_scan.sv */
`default_nettype none
`include "ccl_defs.svh"

module label_scan import ccl_frame_pkg::*, ccl_label_pkg::*; (
    input  wire logic   clk_in,
    input  wire logic   rst_in,
    input  wire logic   scan_start,
    output logic        scan_done,
    output pix_addr_t   mask_raddr,
    input  wire logic   mask_rdata,
    output pix_addr_t   lab_raddr_a,
    output pix_addr_t   lab_raddr_b,
    input  wire label_t lab_rdata_a,
    input  wire label_t lab_rdata_b,
    output logic        lab_we,
    output pix_addr_t   lab_waddr,
    output label_t      lab_wdata,
    output logic        new_valid,
    output label_t      new_label,
    output logic        area_inc_valid,
    output label_t      area_label,
    output logic        merge_valid,
    output label_t      merge_a,
    output label_t      merge_b,
    input  wire logic   merge_ready
);
    localparam logic [2:0] S_IDLE = 3'd0;
    localparam logic [2:0] S_RD1 = 3'd1;
    localparam logic [2:0] S_RD2 = 3'd2;
    localparam logic [2:0] S_EVAL = 3'd3;
    localparam logic [2:0] S_WRITE = 3'd4;

    logic [2:0] st;
    pix_addr_t  addr;
    coord_x_t   x;
    coord_y_t   y;
    label_t     next_label;
    logic       fg;
    logic       is_new;
    label_t     lab_q;
    // neighbors in order nw, n, ne, w
    label_t     nb_q [4];
    label_t     nb_now [4];
    label_t     min_now;
    logic [3:0] pend_q;
    logic [3:0] pend_now;
    logic [3:0] pend_left;
    logic [1:0] merge_sel;
    logic       has_n;
    logic       has_w;
    logic       has_e;
    logic       pix_end;

    // frame edges, outside neighbors read as background
    assign has_n = (y != '0);
    assign has_w = (x != '0);
    assign has_e = (x != coord_x_t'(`CCL_WIDTH - 1));

    // rd1 fetches nw and n, rd2 fetches ne and w
    assign mask_raddr = addr;
    assign lab_raddr_a = (st == S_RD1) ? addr - pix_addr_t'(`CCL_WIDTH + 1)
                                       : addr - pix_addr_t'(`CCL_WIDTH - 1);
    assign lab_raddr_b = (st == S_RD1) ? addr - pix_addr_t'(`CCL_WIDTH) : addr - 1'b1;

    // smallest neighbor label and the distinct others to merge
    always_comb begin
        nb_now[0] = nb_q[0];
        nb_now[1] = nb_q[1];
        nb_now[2] = (has_n && has_e) ? lab_rdata_a : '0;
        nb_now[3] = has_w ? lab_rdata_b : '0;
        min_now = '0;
        for (int i = 0; i < 4; i++) begin
            if (nb_now[i] != '0 && (min_now == '0 || nb_now[i] < min_now)) begin
                min_now = nb_now[i];
            end
        end
        for (int i = 0; i < 4; i++) begin
            pend_now[i] = (nb_now[i] != '0) && (nb_now[i] != min_now);
            // one request per distinct label
            for (int j = 0; j < i; j++) begin
                if (nb_now[j] == nb_now[i]) begin
                    pend_now[i] = 1'b0;
                end
            end
        end
    end

    // lowest pending neighbor goes out first
    always_comb begin
        merge_sel = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (pend_q[i]) begin
                merge_sel = 2'(i);
            end
        end
        merge_valid = (st == S_WRITE) && (pend_q != '0);
        merge_a = lab_q;
        merge_b = nb_q[merge_sel];
        pend_left = pend_q;
        if (merge_valid && merge_ready) begin
            pend_left[merge_sel] = 1'b0;
        end
    end

    // background ends in eval, foreground once merges drain
    assign pix_end = ((st == S_EVAL) && !fg) || ((st == S_WRITE) && (pend_left == '0));

    assign lab_we = pix_end;
    assign lab_waddr = addr;
    assign lab_wdata = (st == S_WRITE) ? lab_q : '0;
    assign area_inc_valid = pix_end && (st == S_WRITE);
    assign area_label = lab_q;
    assign new_valid = area_inc_valid && is_new;
    assign new_label = lab_q;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            st <= S_IDLE;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            case (st)
                S_IDLE: begin
                    if (scan_start) begin
                        st <= S_RD1;
                    end
                end
                S_RD1: st <= S_RD2;
                S_RD2: st <= S_EVAL;
                S_EVAL: begin
                    if (fg) begin
                        st <= S_WRITE;
                    end
                end
                default: ;
            endcase
            if (pix_end) begin
                if (addr == pix_addr_t'(`CCL_PIX_COUNT - 1)) begin
                    st <= S_IDLE;
                    scan_done <= 1'b1;
                end else begin
                    st <= S_RD1;
                end
            end
        end
    end

    // walk position and per-pixel payload
    always_ff @(posedge clk_in) begin
        if (scan_start) begin
            addr <= '0;
            x <= '0;
            y <= '0;
            next_label <= label_t'(1);
        end
        if (st == S_RD2) begin
            fg <= mask_rdata;
            nb_q[0] <= (has_n && has_w) ? lab_rdata_a : '0;
            nb_q[1] <= has_n ? lab_rdata_b : '0;
        end
        if (st == S_EVAL) begin
            nb_q[2] <= nb_now[2];
            nb_q[3] <= nb_now[3];
            pend_q <= pend_now;
            is_new <= (min_now == '0);
            lab_q <= (min_now == '0) ? next_label : min_now;
        end
        if (st == S_WRITE) begin
            pend_q <= pend_left;
        end
        if (new_valid) begin
            next_label <= next_label + 1'b1;
        end
        if (pix_end) begin
            addr <= addr + 1'b1;
            if (x == coord_x_t'(`CCL_WIDTH - 1)) begin
                x <= '0;
                y <= y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

/* label_equiv.sv */
`default_nettype none
`include "ccl_defs.svh"

module label_equiv import ccl_label_pkg::*; (
    input  wire logic   clk_in,
    input  wire logic   rst_in,
    input  wire logic   scan_start,
    input  wire logic   new_valid,
    input  wire label_t new_label,
    input  wire logic   area_inc_valid,
    input  wire label_t area_label,
    input  wire logic   merge_valid,
    input  wire label_t merge_a,
    input  wire label_t merge_b,
    output logic        merge_ready,
    input  wire logic   resolve_start,
    output logic        resolve_done,
    output label_t      label_count,
    input  wire label_t sel_index,
    output label_t      sel_parent,
    output area_t       sel_area
);
    localparam int n_labels = 2 ** `CCL_LABEL_W;

    label_t parent [n_labels];
    area_t  area [n_labels];
    logic   walking;
    label_t walk_a;
    label_t walk_b;
    label_t cur_a;
    label_t cur_b;
    label_t up_a;
    label_t up_b;
    logic   resolving;
    label_t res_idx;
    label_t res_root;

    // first step starts straight from the request
    assign cur_a = walking ? walk_a : merge_a;
    assign cur_b = walking ? walk_b : merge_b;
    assign up_a = parent[cur_a];
    assign up_b = parent[cur_b];
    // both sides at their roots, link in this cycle
    assign merge_ready = merge_valid && (up_a == cur_a) && (up_b == cur_b);

    // parents are smaller, so the grandparent is already a root
    assign res_root = parent[parent[res_idx]];

    assign sel_parent = parent[sel_index];
    assign sel_area = area[sel_index];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            walking <= 1'b0;
            resolving <= 1'b0;
            resolve_done <= 1'b0;
            label_count <= '0;
        end else begin
            resolve_done <= 1'b0;
            if (scan_start) begin
                walking <= 1'b0;
                label_count <= '0;
            end else if (new_valid) begin
                label_count <= new_label;
            end
            if (merge_valid) begin
                walking <= !merge_ready;
                walk_a <= up_a;
                walk_b <= up_b;
            end
            if (resolve_start) begin
                res_idx <= label_t'(1);
                resolving <= (label_count != '0);
                resolve_done <= (label_count == '0);
            end else if (resolving) begin
                if (res_idx == label_count) begin
                    resolving <= 1'b0;
                    resolve_done <= 1'b1;
                end else begin
                    res_idx <= res_idx + 1'b1;
                end
            end
        end
    end

    // parent and area tables
    always_ff @(posedge clk_in) begin
        if (scan_start) begin
            for (int i = 0; i < n_labels; i++) begin
                parent[i] <= label_t'(i);
                area[i] <= '0;
            end
        end else begin
            if (area_inc_valid) begin
                area[area_label] <= area[area_label] + 1'b1;
            end
            // larger root points at the smaller one
            if (merge_ready && cur_a < cur_b) begin
                parent[cur_b] <= cur_a;
            end else if (merge_ready && cur_b < cur_a) begin
                parent[cur_a] <= cur_b;
            end
            if (resolving) begin
                parent[res_idx] <= res_root;
                // fold a child's pixels into its root
                if (res_root != res_idx) begin
                    area[res_root] <= area[res_root] + area[res_idx];
                end
            end
        end
    end
endmodule

`default_nettype wire

/* blob_select.sv */
`default_nettype none

module blob_select import ccl_label_pkg::*; (
    input  wire logic   clk_in,
    input  wire logic   rst_in,
    input  wire logic   select_start,
    output logic        select_done,
    input  wire label_t label_count,
    output label_t      sel_index,
    input  wire label_t sel_parent,
    input  wire area_t  sel_area,
    input  wire area_t  min_area,
    output blob_count_t blob_count,
    output area_t       area_first,
    output area_t       area_second
);
    logic running;
    logic is_blob;

    // a root big enough to survive pruning
    assign is_blob = running && (sel_parent == sel_index) && (sel_area >= min_area);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            running <= 1'b0;
            select_done <= 1'b0;
            sel_index <= '0;
            blob_count <= '0;
            area_first <= '0;
            area_second <= '0;
        end else begin
            select_done <= 1'b0;
            if (select_start) begin
                sel_index <= label_t'(1);
                blob_count <= '0;
                area_first <= '0;
                area_second <= '0;
                running <= (label_count != '0);
                select_done <= (label_count == '0);
            end else if (running) begin
                if (is_blob) begin
                    blob_count <= blob_count + 1'b1;
                    // equal areas may fill both slots
                    if (sel_area > area_first) begin
                        area_first <= sel_area;
                        area_second <= area_first;
                    end else if (sel_area > area_second) begin
                        area_second <= sel_area;
                    end
                end
                if (sel_index == label_count) begin
                    running <= 1'b0;
                    select_done <= 1'b1;
                end else begin
                    sel_index <= sel_index + 1'b1;
                end
            end
        end
    end
endmodule

`default_nettype wire

/* ccl_top.sv */
`default_nettype none
`include "ccl_defs.svh"

module ccl_top import ccl_frame_pkg::*, ccl_label_pkg::*; (
    input  wire logic  clk_in,
    input  wire logic  rst_in,
    input  wire logic  frame_start,
    input  wire logic  pixel_valid,
    input  wire logic  pixel_mask,
    input  wire logic  cfg_valid,
    input  wire area_t cfg_min_area,
    output logic       busy,
    output logic       result_valid,
    output blob_count_t blob_count,
    output area_t      area_first,
    output area_t      area_second
);
    // phase handshakes
    logic scan_start;
    logic scan_done;
    logic resolve_start;
    logic resolve_done;
    logic select_start;
    logic select_done;
    // mask frame
    logic      mask_we;
    pix_addr_t mask_waddr;
    pix_addr_t mask_raddr;
    logic      mask_rdata;
    // label frame
    logic      lab_we;
    pix_addr_t lab_waddr;
    label_t    lab_wdata;
    pix_addr_t lab_raddr_a;
    pix_addr_t lab_raddr_b;
    label_t    lab_rdata_a;
    label_t    lab_rdata_b;
    // scan to equivalence table
    logic   new_valid;
    label_t new_label;
    logic   area_inc_valid;
    label_t area_label;
    logic   merge_valid;
    label_t merge_a;
    label_t merge_b;
    logic   merge_ready;
    // table lookups for selection
    label_t label_count;
    label_t sel_index;
    label_t sel_parent;
    area_t  sel_area;
    area_t  min_area;

    ccl_config i_ccl_config (
        .clk_in(clk_in), .rst_in(rst_in), .cfg_valid(cfg_valid),
        .cfg_min_area(cfg_min_area), .busy(busy), .min_area(min_area)
    );

    ccl_ctrl i_ccl_ctrl (
        .clk_in(clk_in), .rst_in(rst_in), .frame_start(frame_start),
        .pixel_valid(pixel_valid), .mask_we(mask_we), .mask_waddr(mask_waddr),
        .scan_start(scan_start), .scan_done(scan_done),
        .resolve_start(resolve_start), .resolve_done(resolve_done),
        .select_start(select_start), .select_done(select_done),
        .busy(busy), .result_valid(result_valid)
    );

    // second mask read port stays idle
    pixel_ram #(.data_width(1), .depth(`CCL_PIX_COUNT)) mask_ram (
        .clk_in(clk_in), .we(mask_we), .waddr(mask_waddr), .wdata(pixel_mask),
        .raddr_a(mask_raddr), .rdata_a(mask_rdata),
        .raddr_b(mask_raddr), .rdata_b()
    );

    pixel_ram #(.data_width(`CCL_LABEL_W), .depth(`CCL_PIX_COUNT)) label_ram (
        .clk_in(clk_in), .we(lab_we), .waddr(lab_waddr), .wdata(lab_wdata),
        .raddr_a(lab_raddr_a), .rdata_a(lab_rdata_a),
        .raddr_b(lab_raddr_b), .rdata_b(lab_rdata_b)
    );

    label_scan i_label_scan (
        .clk_in(clk_in), .rst_in(rst_in), .scan_start(scan_start), .scan_done(scan_done),
        .mask_raddr(mask_raddr), .mask_rdata(mask_rdata),
        .lab_raddr_a(lab_raddr_a), .lab_raddr_b(lab_raddr_b),
        .lab_rdata_a(lab_rdata_a), .lab_rdata_b(lab_rdata_b),
        .lab_we(lab_we), .lab_waddr(lab_waddr), .lab_wdata(lab_wdata),
        .new_valid(new_valid), .new_label(new_label),
        .area_inc_valid(area_inc_valid), .area_label(area_label),
        .merge_valid(merge_valid), .merge_a(merge_a), .merge_b(merge_b),
        .merge_ready(merge_ready)
    );

    label_equiv i_label_equiv (
        .clk_in(clk_in), .rst_in(rst_in), .scan_start(scan_start),
        .new_valid(new_valid), .new_label(new_label),
        .area_inc_valid(area_inc_valid), .area_label(area_label),
        .merge_valid(merge_valid), .merge_a(merge_a), .merge_b(merge_b),
        .merge_ready(merge_ready), .resolve_start(resolve_start),
        .resolve_done(resolve_done), .label_count(label_count),
        .sel_index(sel_index), .sel_parent(sel_parent), .sel_area(sel_area)
    );

    blob_select i_blob_select (
        .clk_in(clk_in), .rst_in(rst_in), .select_start(select_start),
        .select_done(select_done), .label_count(label_count),
        .sel_index(sel_index), .sel_parent(sel_parent), .sel_area(sel_area),
        .min_area(min_area), .blob_count(blob_count),
        .area_first(area_first), .area_second(area_second)
    );
endmodule

`default_nettype wire

/* tb_ccl.sv */
`default_nettype none
`include "ccl_defs.svh"

module tb_ccl import ccl_label_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int width = `CCL_WIDTH;
    localparam int height = `CCL_HEIGHT;
    localparam int pix_count = `CCL_PIX_COUNT;
    // empty, 20 random, 4 directed, 4 threshold, 2 gap frames
    localparam int n_frames = 31;
    localparam int timeout_limit = n_frames * (2 * pix_count + 40 * pix_count);
    localparam int shape_empty = 0;
    localparam int shape_full = 1;
    localparam int shape_dots = 2;
    localparam int shape_u = 3;
    localparam int shape_spiral = 4;

    logic        clk_in;
    logic        rst_in;
    logic        frame_start;
    logic        pixel_valid;
    logic        pixel_mask;
    logic        cfg_valid;
    area_t       cfg_min_area;
    logic        busy;
    logic        result_valid;
    blob_count_t blob_count;
    area_t       area_first;
    area_t       area_second;

    logic [31:0] lfsr_state;
    bit          frame_bits [pix_count];
    int          cur_min;
    int          error_count;
    int          check_count;
    int          cycle_count;
    bit          watch_busy;
    string       cur_test;

    ccl_top i_ccl_top (
        .clk_in(clk_in), .rst_in(rst_in), .frame_start(frame_start),
        .pixel_valid(pixel_valid), .pixel_mask(pixel_mask),
        .cfg_valid(cfg_valid), .cfg_min_area(cfg_min_area),
        .busy(busy), .result_valid(result_valid), .blob_count(blob_count),
        .area_first(area_first), .area_second(area_second)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic compare_value(input string what, input int expected, input int actual);
        check_count++;
        assert (expected == actual)
        else begin
            error_count++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
        end
    endtask

    function automatic bit shape_pixel(input int shape, input int x, input int y);
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        bit on;
        on = 1'b0;
        if (shape == shape_full) begin
            on = 1'b1;
        end else if (shape == shape_dots) begin
            on = (x % 2 == 0) && (y % 2 == 0);
        end else if (shape == shape_u) begin
            // u closes at the bottom, plus a pruned dot and a 2x2 block
            on = ((x == 2 || x == 3 || x == 12) && y >= 1 && y <= 9)
                || (y == 9 && x >= 2 && x <= 12)
                || (x == 7 && y == 3)
                || (x >= 6 && x <= 7 && y >= 5 && y <= 6);
        end else if (shape == shape_spiral) begin
            // nested rings each cut once and bridged inward on the diagonal
            for (int k = 0; k < 3; k++) begin
                lo_x = 2 * k;
                hi_x = width - 1 - 2 * k;
                lo_y = 2 * k;
                hi_y = height - 1 - 2 * k;
                if (x >= lo_x && x <= hi_x && y >= lo_y && y <= hi_y
                    && (x == lo_x || x == hi_x || y == lo_y || y == hi_y)) begin
                    on = 1'b1;
                end
                if (x == lo_x && y == lo_y + 1) begin
                    on = 1'b0;
                end
                if (k < 2 && x == lo_x + 1 && y == lo_y + 1) begin
                    on = 1'b1;
                end
            end
        end
        return on;
    endfunction

    task automatic fill_shape(input int shape);
        for (int y = 0; y < height; y++) begin
            for (int x = 0; x < width; x++) begin
                frame_bits[y * width + x] = shape_pixel(shape, x, y);
            end
        end
    endtask

    // density in sixteenths
    task automatic fill_random(input int density);
        int v;
        for (int p = 0; p < pix_count; p++) begin
            rand_bits(4, v);
            frame_bits[p] = (v < density);
        end
    endtask

    // 8-connected flood fill, then prune and rank
    task automatic model_frame(input int min_area, output int cnt, output int first,
                               output int second);
        bit seen [pix_count];
        int stack [pix_count];
        int sp;
        int area;
        int q;
        int nx;
        int ny;
        cnt = 0;
        first = 0;
        second = 0;
        for (int p = 0; p < pix_count; p++) begin
            seen[p] = 1'b0;
        end
        for (int p = 0; p < pix_count; p++) begin
            if (frame_bits[p] && !seen[p]) begin
                area = 0;
                sp = 1;
                stack[0] = p;
                seen[p] = 1'b1;
                while (sp > 0) begin
                    sp--;
                    q = stack[sp];
                    area++;
                    for (int dy = -1; dy <= 1; dy++) begin
                        for (int dx = -1; dx <= 1; dx++) begin
                            nx = q % width + dx;
                            ny = q / width + dy;
                            if (nx >= 0 && nx < width && ny >= 0 && ny < height
                                && frame_bits[ny * width + nx] && !seen[ny * width + nx]) begin
                                seen[ny * width + nx] = 1'b1;
                                stack[sp] = ny * width + nx;
                                sp++;
                            end
                        end
                    end
                end
                if (area >= min_area) begin
                    cnt++;
                    if (area > first) begin
                        second = first;
                        first = area;
                    end else if (area > second) begin
                        second = area;
                    end
                end
            end
        end
    endtask

    // written while idle so it applies from the next frame
    task automatic set_min_area(input int value);
        @(posedge clk_in);
        cfg_valid <= 1'b1;
        cfg_min_area <= area_t'(value);
        @(posedge clk_in);
        cfg_valid <= 1'b0;
        cur_min = value;
    endtask

    task automatic run_frame(input string name, input bit gaps, input bit poke_busy);
        int gap;
        int exp_count;
        int exp_first;
        int exp_second;
        cur_test = name;
        model_frame(cur_min, exp_count, exp_first, exp_second);
        @(posedge clk_in);
        frame_start <= 1'b1;
        @(posedge clk_in);
        frame_start <= 1'b0;
        watch_busy = 1'b1;
        for (int p = 0; p < pix_count; p++) begin
            if (gaps) begin
                rand_bits(2, gap);
                repeat (gap) begin
                    pixel_valid <= 1'b0;
                    @(posedge clk_in);
                end
            end
            pixel_valid <= 1'b1;
            pixel_mask <= frame_bits[p];
            // mid-store restart and config attempts
            if (poke_busy && p == pix_count / 2) begin
                frame_start <= 1'b1;
                cfg_valid <= 1'b1;
                // a threshold that no blob can reach
                cfg_min_area <= area_t'(pix_count + 1);
            end
            @(posedge clk_in);
            frame_start <= 1'b0;
            cfg_valid <= 1'b0;
        end
        pixel_valid <= 1'b0;
        pixel_mask <= 1'b0;
        // same again once processing has started
        if (poke_busy) begin
            frame_start <= 1'b1;
            cfg_valid <= 1'b1;
            @(posedge clk_in);
            frame_start <= 1'b0;
            cfg_valid <= 1'b0;
        end
        do begin
            @(negedge clk_in);
        end while (!result_valid);
        watch_busy = 1'b0;
        compare_value("busy at result_valid", 0, busy);
        compare_value("blob_count", exp_count, blob_count);
        compare_value("area_first", exp_first, area_first);
        compare_value("area_second", exp_second, area_second);
        @(negedge clk_in);
        compare_value("result_valid after one cycle", 0, result_valid);
    endtask

    // busy must hold from frame_start up to the result strobe
    always @(negedge clk_in) begin
        if (watch_busy && !result_valid) begin
            assert (busy)
            else begin
                error_count++;
                $display("%s: busy went low before result_valid", cur_test);
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_limit) begin
            @(posedge clk_in);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", timeout_limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        rst_in = 1'b1;
        frame_start = 1'b0;
        pixel_valid = 1'b0;
        pixel_mask = 1'b0;
        cfg_valid = 1'b0;
        cfg_min_area = area_t'(`CCL_MIN_AREA_RESET);
        lfsr_state = 32'h90c428b7;
        cur_min = `CCL_MIN_AREA_RESET;
        error_count = 0;
        check_count = 0;
        watch_busy = 1'b0;
        repeat (5) @(posedge clk_in);
        rst_in <= 1'b0;
        @(negedge clk_in);
        cur_test = "reset";
        compare_value("busy", 0, busy);
        compare_value("result_valid", 0, result_valid);
        fill_shape(shape_empty);
        run_frame("empty frame", 1'b0, 1'b0);
        // sparse to dense, some with gaps, some poked while busy
        for (int i = 0; i < 20; i++) begin
            fill_random(1 + (i * 14) / 19);
            run_frame($sformatf("random frame %0d", i), (i % 3) == 1, (i % 5) == 2);
        end
        fill_shape(shape_full);
        run_frame("full frame", 1'b0, 1'b0);
        set_min_area(1);
        fill_shape(shape_dots);
        run_frame("dot grid", 1'b0, 1'b0);
        set_min_area(3);
        fill_shape(shape_u);
        run_frame("u shape", 1'b0, 1'b0);
        fill_shape(shape_spiral);
        run_frame("spiral", 1'b1, 1'b0);
        // threshold changes between frames
        set_min_area(6);
        fill_random(7);
        run_frame("min area 6", 1'b0, 1'b0);
        set_min_area(12);
        fill_random(9);
        run_frame("min area 12, cfg while busy", 1'b0, 1'b1);
        fill_random(9);
        run_frame("frame after cfg while busy", 1'b0, 1'b0);
        set_min_area(1);
        fill_random(5);
        run_frame("min area 1", 1'b0, 1'b0);
        // one frame with and without pixel gaps
        fill_random(8);
        run_frame("frame without gaps", 1'b0, 1'b0);
        run_frame("same frame with gaps", 1'b1, 1'b1);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* flist.f */
+incdir+.
ccl_frame_pkg.sv
ccl_label_pkg.sv
pixel_ram.sv
ccl_config.sv
ccl_ctrl.sv
label_scan.sv
label_equiv.sv
blob_select.sv
ccl_top.sv
tb_ccl.sv
